// File: verilog.f
hdl/bft_pkg.sv
hdl/leaf_pkg.sv
hdl/route_cfg_if.sv
hdl/leaf_depacketizer.sv
hdl/port_fifo.sv
hdl/leaf_packetizer.sv
hdl/leaf_interface.sv
test/leaf_interface_props.sv
test/leaf_interface_tb.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module leaf_interface_tb -f verilog.f -o leaf_sim

./obj_dir/leaf_sim 2>&1 | tee sim.log

if grep -q "=== FAIL ===" sim.log; then
    exit 1
fi
if ! grep -q "=== PASS ===" sim.log; then
    exit 1
fi
exit 0

// File: test/leaf_interface_tb.sv
`timescale 1ns/1ps

module leaf_interface_tb;

    localparam int NI    = 3;
    localparam int NO    = 2;
    localparam int DEPTH = 4;
    localparam bft_pkg::leaf_id_t LEAF = 5'd3;

    logic                 clk;
    logic                 rst_n;
    logic                 resend;
    bft_pkg::packet_t     din;
    bft_pkg::packet_t     dout;
    logic [NI*32-1:0]     user_out;
    logic [NI-1:0]        vld_i2u;
    logic [NI-1:0]        ack_u2i;
    logic [NO*32-1:0]     user_in;
    logic [NO-1:0]        vld_u2i;
    logic [NO-1:0]        ack_i2u;

    logic [31:0]          seed = 32'hcb22_7e90;
    leaf_pkg::word_t      in_exp [NI][$];   // expected words per user input port
    leaf_pkg::word_t      out_exp [NO][$];  // accepted user words not yet on the bus
    int                   outstanding [NI];
    leaf_pkg::route_t     route_m [NO];
    bit                   rand_in_en, rand_out_en, rand_ack, rand_resend, hold_resend;
    logic [NI-1:0]        ack_hold_low;
    logic [NO-1:0]        out_force;
    bit                   direct_valid;
    bft_pkg::packet_t     direct_pkt;
    int                   burst_left;

    leaf_interface #(
        .NUM_IN_PORTS  (NI),
        .NUM_OUT_PORTS (NO),
        .FIFO_DEPTH    (DEPTH),
        .LEAF_ID       (LEAF)
    ) UUT (
        .clk                      (clk),
        .rst_n                    (rst_n),
        .resend                   (resend),
        .din_leaf_bft2interface   (din),
        .dout_leaf_interface2bft  (dout),
        .dout_leaf_interface2user (user_out),
        .vld_interface2user       (vld_i2u),
        .ack_user2interface       (ack_u2i),
        .din_leaf_user2interface  (user_in),
        .vld_user2interface       (vld_u2i),
        .ack_interface2user       (ack_i2u)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] next_rand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function automatic bft_pkg::packet_t make_pkt(logic v, bft_pkg::leaf_id_t l,
                                                  bft_pkg::port_id_t p, leaf_pkg::word_t d);
        bft_pkg::packet_t pk;
        pk = '0;
        pk[bft_pkg::VALID_POS] = v;
        pk[bft_pkg::LEAF_MSB:bft_pkg::LEAF_LSB] = l;
        pk[bft_pkg::PORT_MSB:bft_pkg::PORT_LSB] = p;
        pk[bft_pkg::PAYLOAD_MSB:bft_pkg::PAYLOAD_LSB] = d;
        return pk;
    endfunction

    // which output port owns a header, -1 if none
    function automatic int port_of(bft_pkg::packet_t pk);
        for (int p = 0; p < NO; p++) begin
            if (pk[bft_pkg::LEAF_MSB:bft_pkg::LEAF_LSB] == route_m[p][8:4] &&
                pk[bft_pkg::PORT_MSB:bft_pkg::PORT_LSB] == route_m[p][3:0]) begin
                return p;
            end
        end
        return -1;
    endfunction

    task automatic fail_with(string msg);
        $display("%s", msg);
        $display("=== FAIL ===");
        $fatal(1);
    endtask

    task automatic check_word(string name, leaf_pkg::word_t exp, leaf_pkg::word_t act);
        if (act !== exp) begin
            $display("[FAIL] %0t %s expected %h got %h", $time, name, exp, act);
            fail_with("user word mismatch");
        end
    endtask

    task automatic check_packet(string name, bft_pkg::packet_t exp, bft_pkg::packet_t act);
        if (act !== exp) begin
            $display("[FAIL] %0t %s expected %h got %h", $time, name, exp, act);
            fail_with("tree packet mismatch");
        end
    endtask

    task automatic check_bit(string name, logic exp, logic act);
        if (act !== exp) begin
            $display("[FAIL] %0t %s expected %b got %b", $time, name, exp, act);
            fail_with("flag mismatch");
        end
    endtask

    // runs at the falling edge, where every output is settled
    task automatic monitor();
        int p;
        bft_pkg::packet_t exp;
        if (resend) begin
            check_packet("dout_leaf_interface2bft", '0, dout);
        end else if (dout[bft_pkg::VALID_POS]) begin
            p = port_of(dout);
            if (p < 0) fail_with("packet header matches no programmed route");
            if (out_exp[p].size() == 0) fail_with("packet on the tree bus with no word queued");
            exp = make_pkt(1'b1, route_m[p][8:4], route_m[p][3:0], out_exp[p].pop_front());
            check_packet("dout_leaf_interface2bft", exp, dout);
        end else begin
            check_packet("dout_leaf_interface2bft", '0, dout);
        end
        for (int i = 0; i < NI; i++) begin
            if (vld_i2u[i] && ack_u2i[i]) begin
                if (in_exp[i].size() == 0) begin
                    fail_with("word delivered on a user port with none sent");
                end
                check_word($sformatf("dout_leaf_interface2user[%0d]", i), in_exp[i].pop_front(),
                           user_out[i*32 +: 32]);
                outstanding[i]--;
            end
        end
        for (int i = 0; i < NO; i++) begin
            if (vld_u2i[i] && ack_i2u[i]) out_exp[i].push_back(user_in[i*32 +: 32]);
        end
    endtask

    task automatic note_sent(bft_pkg::packet_t pk);
        int p;
        p = int'(pk[bft_pkg::PORT_MSB:bft_pkg::PORT_LSB]);
        if (pk[bft_pkg::VALID_POS] && pk[bft_pkg::LEAF_MSB:bft_pkg::LEAF_LSB] == LEAF &&
            p >= 1 && p <= NI) begin
            in_exp[p-1].push_back(pk[31:0]);
            outstanding[p-1]++;
        end
    endtask

    // runs at the rising edge
    task automatic drive_inputs();
        bft_pkg::packet_t pk;
        logic [31:0] r;
        logic [31:0] r2;
        int lf;
        int p;
        pk = '0;
        r  = next_rand();
        r2 = next_rand();
        if (direct_valid) begin
            pk = direct_pkt;
            direct_valid = 1'b0;
            note_sent(pk);
        end else if (rand_in_en) begin
            lf = (int'(LEAF) + 1 + int'(r[12:8]) % 31) % 32;
            p  = int'(r[17:16]) % NI;
            case (r[2:0])
                3'd0: pk = make_pkt(1'b1, 5'(lf), r[21:18], next_rand());
                3'd1: pk = make_pkt(1'b0, LEAF, 4'(p + 1), next_rand());
                3'd2: pk = make_pkt(1'b1, LEAF, 4'(4 + int'(r[21:18]) % 12), next_rand());
                3'd3: pk = '0;
                default: begin
                    if (outstanding[p] < DEPTH) begin
                        pk = make_pkt(1'b1, LEAF, 4'(p + 1), next_rand());
                        note_sent(pk);
                    end
                end
            endcase
        end
        din <= pk;
        for (int i = 0; i < NI; i++) begin
            ack_u2i[i] <= ack_hold_low[i] ? 1'b0 : (rand_ack ? (r2[i] | r2[i+8]) : 1'b1);
        end
        for (int i = 0; i < NO; i++) begin
            vld_u2i[i] <= out_force[i] | (rand_out_en & r2[16+i]);
            user_in[i*32 +: 32] <= next_rand();
        end
        if (hold_resend) begin
            resend <= 1'b1;
        end else if (rand_resend && burst_left > 0) begin
            resend <= 1'b1;
            burst_left--;
        end else if (rand_resend && r2[27:24] == 4'd0) begin
            resend <= 1'b1;
            burst_left = int'(r2[29:28]);
        end else begin
            resend <= 1'b0;
        end
    endtask

    task automatic cycle();
        @(negedge clk);
        monitor();
        @(posedge clk);
        drive_inputs();
    endtask

    task automatic send_config(int oport, bft_pkg::leaf_id_t l, bft_pkg::port_id_t dp);
        leaf_pkg::word_t pl;
        pl = '0;
        pl[3:0]  = 4'(oport);
        pl[8:4]  = l;
        pl[12:9] = dp;
        direct_pkt   = make_pkt(1'b1, LEAF, bft_pkg::CFG_PORT, pl);
        direct_valid = 1'b1;
        route_m[oport-1] = {l, dp};
        repeat (4) cycle();
    endtask

    task automatic wait_drained(int limit);
        int n;
        bit busy;
        n = 0;
        busy = 1'b1;
        while (busy) begin
            cycle();
            busy = 1'b0;
            for (int i = 0; i < NI; i++) busy |= (in_exp[i].size() != 0);
            for (int i = 0; i < NO; i++) busy |= (out_exp[i].size() != 0);
            n++;
            if (busy && n >= limit) fail_with("timeout while waiting for the queues to drain");
        end
    endtask

    task automatic random_phase(int cycles);
        rand_in_en = 1;
        rand_out_en = 1;
        rand_ack = 1;
        rand_resend = 1;
        repeat (cycles) cycle();
        rand_in_en = 0;
        rand_out_en = 0;
        rand_resend = 0;
        burst_left = 0;
        wait_drained(300);
    endtask

    initial begin
        int n;
        rst_n <= 1'b0;
        resend <= 1'b0;
        din <= '0;
        ack_u2i <= '0;
        user_in <= '0;
        vld_u2i <= '0;
        {rand_in_en, rand_out_en, rand_ack, rand_resend, hold_resend} = '0;
        ack_hold_low = '0;
        out_force = '0;
        direct_valid = 0;
        burst_left = 0;
        for (int i = 0; i < NI; i++) outstanding[i] = 0;
        for (int i = 0; i < NO; i++) route_m[i] = '0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;

        // idle state right after reset
        @(negedge clk);
        for (int i = 0; i < NI; i++) begin
            check_bit($sformatf("vld_interface2user[%0d]", i), 1'b0, vld_i2u[i]);
        end
        for (int i = 0; i < NO; i++) begin
            check_bit($sformatf("ack_interface2user[%0d]", i), 1'b1, ack_i2u[i]);
        end
        check_packet("dout_leaf_interface2bft", '0, dout);

        // first word shows up two cycles after it is on the bus
        ack_hold_low = '1;
        direct_pkt = make_pkt(1'b1, LEAF, 4'd1, 32'h1234_abcd);
        direct_valid = 1'b1;
        @(posedge clk);
        drive_inputs();
        for (int k = 0; k < 3; k++) begin
            @(negedge clk);
            check_bit("vld_interface2user[0]", (k == 2), vld_i2u[0]);
            monitor();
            @(posedge clk);
            drive_inputs();
        end
        ack_hold_low = '0;
        wait_drained(20);

        send_config(1, 5'd7, 4'd2);
        send_config(2, 5'd9, 4'd5);
        random_phase(400);

        // new routes must show in later headers
        send_config(1, 5'(next_rand()), 4'(2 * (next_rand() % 8)));
        send_config(2, 5'(next_rand()), 4'(2 * (next_rand() % 8) + 1));
        random_phase(300);

        // stalled user fills input queue 2
        ack_hold_low = 3'b010;
        rand_in_en = 1;
        repeat (80) cycle();
        @(negedge clk);
        check_bit("vld_interface2user[1]", 1'b1, vld_i2u[1]);
        monitor();
        @(posedge clk);
        drive_inputs();
        rand_in_en = 0;
        ack_hold_low = '0;
        wait_drained(100);

        // output queue fills while the tree asks for a resend
        hold_resend = 1;
        out_force = 2'b01;
        n = 0;
        while (out_exp[0].size() < DEPTH) begin
            cycle();
            n++;
            if (n >= 30) fail_with("timeout while filling output queue 1");
        end
        repeat (4) begin
            @(negedge clk);
            check_bit("ack_interface2user[0]", 1'b0, ack_i2u[0]);
            monitor();
            @(posedge clk);
            drive_inputs();
        end
        hold_resend = 0;
        out_force = '0;
        wait_drained(50);

        $display("=== PASS ===");
        $finish;
    end

endmodule

// File: test/leaf_interface_props.sv
`timescale 1ns/1ps

module leaf_interface_props #(
    parameter int NUM_IN_PORTS  = 3,
    parameter int NUM_OUT_PORTS = 2,
    parameter int FIFO_DEPTH    = 4
) (
    input logic                     clk,
    input logic                     rst_n,
    input logic                     resend,
    input bft_pkg::packet_t         dout,
    input logic [NUM_IN_PORTS-1:0]  vld_user,
    input logic [NUM_IN_PORTS-1:0]  ack_user,
    input logic [NUM_IN_PORTS-1:0]  in_we,
    input logic [NUM_OUT_PORTS-1:0] out_pop,
    input logic [NUM_OUT_PORTS-1:0] out_empty
);

    for (genvar i = 0; i < NUM_IN_PORTS; i++) begin : g_in
        int occ;  // words held in input queue i

        always_ff @(posedge clk) begin
            if (!rst_n) begin
                occ <= 0;
            end else begin
                occ <= occ + int'(in_we[i] && occ < FIFO_DEPTH) - int'(vld_user[i] && ack_user[i]);
            end
        end

        a_in_not_full: assert property (@(posedge clk) disable iff (!rst_n)
            in_we[i] |-> occ < FIFO_DEPTH)
            else $error("input queue %0d written while full", i);
    end

    a_out_pop: assert property (@(posedge clk) disable iff (!rst_n)
        (out_pop & out_empty) == '0)
        else $error("output queue popped while empty");

    a_resend_quiet: assert property (@(posedge clk) disable iff (!rst_n)
        resend |-> !dout[bft_pkg::VALID_POS])
        else $error("valid packet on the tree bus during resend");

    a_reset_vld: assert property (@(posedge clk) !rst_n |=> vld_user == '0)
        else $error("user valid high right after reset");

endmodule

bind leaf_interface leaf_interface_props #(
    .NUM_IN_PORTS  (NUM_IN_PORTS),
    .NUM_OUT_PORTS (NUM_OUT_PORTS),
    .FIFO_DEPTH    (FIFO_DEPTH)
) u_props (
    .clk       (clk),
    .rst_n     (rst_n),
    .resend    (resend),
    .dout      (dout_leaf_interface2bft),
    .vld_user  (vld_interface2user),
    .ack_user  (ack_user2interface),
    .in_we     (in_we),
    .out_pop   (out_pop),
    .out_empty (out_empty)
);

// File: hdl/leaf_interface.sv
`timescale 1ns/1ps

module leaf_interface #(
    parameter int                NUM_IN_PORTS  = 3,
    parameter int                NUM_OUT_PORTS = 2,
    parameter int                FIFO_DEPTH    = 4,
    parameter bft_pkg::leaf_id_t LEAF_ID       = 5'd3
) (
    input  logic                                        clk,
    input  logic                                        rst_n,
    input  logic                                        resend,

    input  bft_pkg::packet_t                            din_leaf_bft2interface,
    output bft_pkg::packet_t                            dout_leaf_interface2bft,

    output logic [NUM_IN_PORTS*leaf_pkg::WORD_BITS-1:0] dout_leaf_interface2user,
    output logic [NUM_IN_PORTS-1:0]                     vld_interface2user,
    input  logic [NUM_IN_PORTS-1:0]                     ack_user2interface,

    input  logic [NUM_OUT_PORTS*leaf_pkg::WORD_BITS-1:0] din_leaf_user2interface,
    input  logic [NUM_OUT_PORTS-1:0]                     vld_user2interface,
    output logic [NUM_OUT_PORTS-1:0]                     ack_interface2user
);

    localparam int W = leaf_pkg::WORD_BITS;

    logic [NUM_IN_PORTS-1:0]                 in_we;
    leaf_pkg::word_t                         in_wdata;
    logic [NUM_IN_PORTS-1:0]                 in_empty;

    logic [NUM_OUT_PORTS-1:0]                out_pop;
    logic [NUM_OUT_PORTS-1:0]                out_full;
    logic [NUM_OUT_PORTS-1:0]                out_empty;
    leaf_pkg::word_t [NUM_OUT_PORTS-1:0]     out_data;

    route_cfg_if cfg_if ();

    leaf_depacketizer #(
        .NUM_IN_PORTS (NUM_IN_PORTS),
        .LEAF_ID      (LEAF_ID)
    ) u_depacketizer (
        .clk        (clk),
        .rst_n      (rst_n),
        .din        (din_leaf_bft2interface),
        .fifo_we    (in_we),
        .fifo_wdata (in_wdata),
        .cfg        (cfg_if)
    );

    // user input port i+1 sits in slice i of the flat bus
    for (genvar i = 0; i < NUM_IN_PORTS; i++) begin : g_in_q
        port_fifo #(
            .DEPTH (FIFO_DEPTH),
            .WIDTH (W)
        ) u_fifo (
            .clk   (clk),
            .rst_n (rst_n),
            .push  (in_we[i]),
            .wdata (in_wdata),
            .pop   (ack_user2interface[i]),  // ignored while empty
            .rdata (dout_leaf_interface2user[i*W +: W]),
            .full  (),                       // held off by the sender's credit limit
            .empty (in_empty[i])
        );

        assign vld_interface2user[i] = !in_empty[i];
    end

    for (genvar i = 0; i < NUM_OUT_PORTS; i++) begin : g_out_q
        port_fifo #(
            .DEPTH (FIFO_DEPTH),
            .WIDTH (W)
        ) u_fifo (
            .clk   (clk),
            .rst_n (rst_n),
            .push  (vld_user2interface[i]),  // ignored while full
            .wdata (din_leaf_user2interface[i*W +: W]),
            .pop   (out_pop[i]),
            .rdata (out_data[i]),
            .full  (out_full[i]),
            .empty (out_empty[i])
        );

        assign ack_interface2user[i] = !out_full[i];
    end

    leaf_packetizer #(
        .NUM_OUT_PORTS (NUM_OUT_PORTS)
    ) u_packetizer (
        .clk     (clk),
        .rst_n   (rst_n),
        .resend  (resend),
        .cfg     (cfg_if),
        .q_empty (out_empty),
        .q_data  (out_data),
        .q_pop   (out_pop),
        .dout    (dout_leaf_interface2bft)
    );

endmodule

// File: hdl/leaf_packetizer.sv
`timescale 1ns/1ps

module leaf_packetizer #(
    parameter int NUM_OUT_PORTS = 2
) (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  logic                                   resend,
    route_cfg_if.slave                             cfg,
    input  logic [NUM_OUT_PORTS-1:0]               q_empty,
    input  leaf_pkg::word_t [NUM_OUT_PORTS-1:0]    q_data,
    output logic [NUM_OUT_PORTS-1:0]               q_pop,
    output bft_pkg::packet_t                       dout
);

    localparam int IDX_BITS = (NUM_OUT_PORTS > 1) ? $clog2(NUM_OUT_PORTS) : 1;

    leaf_pkg::route_t    route_tbl [NUM_OUT_PORTS];
    logic [IDX_BITS-1:0] last_q;     // last queue served
    logic [IDX_BITS-1:0] grant_idx;
    logic                grant_vld;
    logic                take;
    logic                out_vld;
    leaf_pkg::route_t    out_route;
    leaf_pkg::word_t     out_data;
    bft_pkg::packet_t    out_pkt;

    // user port n lives in row n-1
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_OUT_PORTS; i++) begin
                route_tbl[i] <= '0;
            end
        end else if (cfg.we) begin
            for (int i = 0; i < NUM_OUT_PORTS; i++) begin
                if (cfg.out_port == bft_pkg::port_id_t'(i + 1)) begin
                    route_tbl[i] <= cfg.route;
                end
            end
        end
    end

    // search starts one past the last served queue
    always_comb begin
        int idx;
        grant_vld = 1'b0;
        grant_idx = last_q;
        for (int j = 1; j <= NUM_OUT_PORTS; j++) begin
            idx = (int'(last_q) + j) % NUM_OUT_PORTS;
            if (!grant_vld && !q_empty[idx]) begin
                grant_vld = 1'b1;
                grant_idx = IDX_BITS'(idx);
            end
        end
    end

    // with resend low the held packet leaves this cycle, so the register is free
    assign take = grant_vld && !resend;

    always_comb begin
        for (int i = 0; i < NUM_OUT_PORTS; i++) begin
            q_pop[i] = take && (grant_idx == IDX_BITS'(i));
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_vld <= 1'b0;
            last_q  <= IDX_BITS'(NUM_OUT_PORTS - 1);  // port 1 wins first
        end else if (!resend) begin
            out_vld <= grant_vld;
            if (grant_vld) begin
                last_q <= grant_idx;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            out_route <= route_tbl[grant_idx];
            out_data  <= q_data[grant_idx];
        end
    end

    always_comb begin
        out_pkt[bft_pkg::VALID_POS] = 1'b1;
        out_pkt[bft_pkg::LEAF_MSB:bft_pkg::LEAF_LSB] =
            out_route[leaf_pkg::ROUTE_LEAF_MSB:leaf_pkg::ROUTE_LEAF_LSB];
        out_pkt[bft_pkg::PORT_MSB:bft_pkg::PORT_LSB] =
            out_route[leaf_pkg::ROUTE_PORT_MSB:leaf_pkg::ROUTE_PORT_LSB];
        out_pkt[bft_pkg::RSVD_MSB:bft_pkg::RSVD_LSB] = '0;
        out_pkt[bft_pkg::PAYLOAD_MSB:bft_pkg::PAYLOAD_LSB] = out_data;
    end

    // idle bus and resend both show all zeros
    assign dout = (out_vld && !resend) ? out_pkt : '0;

endmodule

// File: hdl/port_fifo.sv
`timescale 1ns/1ps

module port_fifo #(
    parameter int DEPTH = 4,
    parameter int WIDTH = 32
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             push,
    input  logic [WIDTH-1:0] wdata,
    input  logic             pop,
    output logic [WIDTH-1:0] rdata,
    output logic             full,
    output logic             empty
);

    localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    logic [WIDTH-1:0]    mem [DEPTH];
    logic [PTR_BITS-1:0] wr_ptr;
    logic [PTR_BITS-1:0] rd_ptr;
    logic [PTR_BITS:0]   count;
    logic                do_push;
    logic                do_pop;

    assign do_push = push && !full;   // push into a full queue is lost
    assign do_pop  = pop && !empty;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= wdata;
        end
    end

    assign rdata = mem[rd_ptr];  // fall-through head word
    assign full  = (count == (PTR_BITS + 1)'(DEPTH));
    assign empty = (count == '0);

endmodule

// File: hdl/leaf_depacketizer.sv
`timescale 1ns/1ps

module leaf_depacketizer #(
    parameter int                NUM_IN_PORTS = 3,
    parameter bft_pkg::leaf_id_t LEAF_ID      = 5'd0
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  bft_pkg::packet_t        din,
    output logic [NUM_IN_PORTS-1:0] fifo_we,
    output leaf_pkg::word_t         fifo_wdata,
    route_cfg_if.master             cfg
);

    logic              vld_q;
    bft_pkg::leaf_id_t leaf_q;
    bft_pkg::port_id_t port_q;
    leaf_pkg::word_t   payload_q;
    logic              leaf_hit;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            vld_q <= 1'b0;
        end else begin
            vld_q <= din[bft_pkg::VALID_POS];
        end
    end

    always_ff @(posedge clk) begin
        leaf_q    <= din[bft_pkg::LEAF_MSB:bft_pkg::LEAF_LSB];
        port_q    <= din[bft_pkg::PORT_MSB:bft_pkg::PORT_LSB];
        payload_q <= din[bft_pkg::PAYLOAD_MSB:bft_pkg::PAYLOAD_LSB];
    end

    assign leaf_hit = vld_q && (leaf_q == LEAF_ID);

    // port 0 programs the route table
    assign cfg.we       = leaf_hit && (port_q == bft_pkg::CFG_PORT);
    assign cfg.out_port = payload_q[leaf_pkg::CFG_OPORT_MSB:leaf_pkg::CFG_OPORT_LSB];
    assign cfg.route    = {payload_q[leaf_pkg::CFG_LEAF_MSB:leaf_pkg::CFG_LEAF_LSB],
                           payload_q[leaf_pkg::CFG_DPORT_MSB:leaf_pkg::CFG_DPORT_LSB]};

    // ports above NUM_IN_PORTS match no bit and are dropped
    always_comb begin
        for (int i = 0; i < NUM_IN_PORTS; i++) begin
            fifo_we[i] = leaf_hit && (port_q == bft_pkg::port_id_t'(i + 1));
        end
    end

    assign fifo_wdata = payload_q;  // shared by all input queues

endmodule

// File: hdl/route_cfg_if.sv
`timescale 1ns/1ps

interface route_cfg_if;

    logic                we;        // one cycle per accepted config packet
    bft_pkg::port_id_t   out_port;  // 1..NUM_OUT_PORTS
    leaf_pkg::route_t    route;

    modport master (
        output we,
        output out_port,
        output route
    );

    modport slave (
        input we,
        input out_port,
        input route
    );

endinterface

// File: hdl/leaf_pkg.sv
package leaf_pkg;

    localparam int WORD_BITS  = 32;
    localparam int ROUTE_BITS = bft_pkg::LEAF_BITS + bft_pkg::PORT_BITS;

    typedef logic [WORD_BITS-1:0] word_t;

    // same order as the packet header, leaf above port
    typedef logic [ROUTE_BITS-1:0] route_t;

    localparam int ROUTE_LEAF_MSB = ROUTE_BITS - 1;
    localparam int ROUTE_LEAF_LSB = bft_pkg::PORT_BITS;
    localparam int ROUTE_PORT_MSB = bft_pkg::PORT_BITS - 1;
    localparam int ROUTE_PORT_LSB = 0;

    // config payload layout
    localparam int CFG_OPORT_MSB = 3;   // output port to program
    localparam int CFG_OPORT_LSB = 0;
    localparam int CFG_LEAF_MSB  = 8;   // destination leaf
    localparam int CFG_LEAF_LSB  = 4;
    localparam int CFG_DPORT_MSB = 12;  // destination port
    localparam int CFG_DPORT_LSB = 9;

endpackage

// File: hdl/bft_pkg.sv
package bft_pkg;

    localparam int PACKET_BITS  = 49;
    localparam int PAYLOAD_BITS = 32;
    localparam int LEAF_BITS    = 5;
    localparam int PORT_BITS    = 4;

    // field positions inside a tree packet
    localparam int VALID_POS    = 48;
    localparam int LEAF_MSB     = 47;
    localparam int LEAF_LSB     = 43;
    localparam int PORT_MSB     = 42;
    localparam int PORT_LSB     = 39;
    localparam int RSVD_MSB     = 38;  // reserved, always zero on the bus
    localparam int RSVD_LSB     = 32;
    localparam int PAYLOAD_MSB  = 31;
    localparam int PAYLOAD_LSB  = 0;

    typedef logic [PACKET_BITS-1:0] packet_t;
    typedef logic [LEAF_BITS-1:0]   leaf_id_t;
    typedef logic [PORT_BITS-1:0]   port_id_t;

    // port 0 of a leaf is its route-table configuration port
    localparam port_id_t CFG_PORT = 4'd0;

endpackage
